/* fetch_unit.f */
src/fetch_pkg.sv
src/rvc_expand.sv
src/pc_gen.sv
src/fetch_align.sv
src/fetch_out_reg.sv
src/fetch_unit.sv
testbench/imem_model.sv
testbench/tb_fetch_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch_unit -f fetch_unit.f
out=$(./obj_dir/Vtb_fetch_unit)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
    exit 0
fi
exit 1

/* testbench/tb_fetch_unit.sv */
`timescale 1ns/1ps

module tb_fetch_unit;
    import fetch_pkg::*;

    // expected instruction, kind, length in bytes
    localparam logic [36:0] ENTRY_TAB [43] = '{
        {32'h00500093, KIND_OTHER, 3'd4},  {32'h00208463, KIND_BRANCH, 3'd4},
        {32'h010000ef, KIND_JUMP, 3'd4},   {32'h00008067, KIND_JUMP, 3'd4},
        {32'h01010413, KIND_OTHER, 3'd2},  {32'h00442483, KIND_OTHER, 3'd2},
        {32'h00942423, KIND_OTHER, 3'd2},  {32'h00000013, KIND_OTHER, 3'd2},
        {32'hfff40413, KIND_OTHER, 3'd2},  {32'h008000ef, KIND_JUMP, 3'd2},
        {32'h00500513, KIND_OTHER, 3'd2},  {32'h02010113, KIND_OTHER, 3'd2},
        {32'h000015b7, KIND_OTHER, 3'd2},  {32'h00245413, KIND_OTHER, 3'd2},
        {32'h40245413, KIND_OTHER, 3'd2},  {32'h00747413, KIND_OTHER, 3'd2},
        {32'h40940433, KIND_OTHER, 3'd2},  {32'h00944433, KIND_OTHER, 3'd2},
        {32'h00946433, KIND_OTHER, 3'd2},  {32'h00947433, KIND_OTHER, 3'd2},
        {32'hffdff06f, KIND_JUMP, 3'd2},   {32'h00040363, KIND_BRANCH, 3'd2},
        {32'h00041363, KIND_BRANCH, 3'd2}, {32'h00341413, KIND_OTHER, 3'd2},
        {32'h00812503, KIND_OTHER, 3'd2},  {32'h00008067, KIND_JUMP, 3'd2},
        {32'h00b00533, KIND_OTHER, 3'd2},  {32'h00100073, KIND_OTHER, 3'd2},
        {32'h000080e7, KIND_JUMP, 3'd2},   {32'h00b50533, KIND_OTHER, 3'd2},
        {32'h00912223, KIND_OTHER, 3'd2},  {32'h00000000, KIND_OTHER, 3'd2},
        {32'h00500513, KIND_OTHER, 3'd2},  {32'h00500093, KIND_OTHER, 3'd4},
        {32'h00000013, KIND_OTHER, 3'd2},  {32'h00208463, KIND_BRANCH, 3'd4},
        {32'h00040363, KIND_BRANCH, 3'd2}, {32'h010000ef, KIND_JUMP, 3'd4},
        {32'h00008067, KIND_JUMP, 3'd2},   {32'h00008067, KIND_JUMP, 3'd4},
        {32'h00b00533, KIND_OTHER, 3'd2},  {32'h00912223, KIND_OTHER, 3'd4},
        {32'h00100073, KIND_OTHER, 3'd2}
    };

    localparam int NUM_ROWS = 5;
    localparam pc_t ROW_START [NUM_ROWS] = '{32'h4000_0000, 32'h4000_0010, 32'h4000_0100,
                                             32'h4000_0100, 32'h4000_0102};
    localparam int ROW_FIRST [NUM_ROWS] = '{0, 4, 32, 32, 33};
    localparam int ROW_COUNT [NUM_ROWS] = '{4, 28, 11, 11, 3};
    localparam logic ROW_RANDOM [NUM_ROWS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0};

    string row_name [NUM_ROWS] = '{"aligned32", "compressed", "mixed", "mixed_random",
                                   "redirect_split"};

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    logic        flush_i;
    logic        redirect_valid_i;
    pc_t         redirect_pc_i;
    logic        wait_req;
    logic        imem_wait;
    instr_t      imem_data;
    pc_t         imem_addr;
    logic        instr_valid_o;
    instr_t      instr_o;
    pc_t         instr_pc_o;
    pc_t         instr_pc_next_o;
    instr_kind_e instr_kind_o;
    logic [15:0] lfsr;
    int          checks;
    int          errors;

    fetch_unit #(
        .RESET_PC (32'h4000_0000)
    ) i_fetch_unit (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .flush_i          (flush_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .imem_data_i      (imem_data),
        .imem_wait_i      (imem_wait),
        .imem_addr_o      (imem_addr),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .instr_pc_next_o  (instr_pc_next_o),
        .instr_kind_o     (instr_kind_o)
    );

    imem_model i_imem (
        .clk_i      (clk_i),
        .addr_i     (imem_addr),
        .wait_req_i (wait_req),
        .data_o     (imem_data),
        .wait_o     (imem_wait)
    );

    always #5 clk_i = ~clk_i;

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bit(output logic b);
        b    = lfsr[0];
        lfsr = lfsr_next(lfsr);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // about one cycle in four stalls, one in four waits
    task automatic drive_random(input logic en);
        logic s0;
        logic s1;
        logic w0;
        logic w1;
        if (en) begin
            take_bit(s0);
            take_bit(s1);
            take_bit(w0);
            take_bit(w1);
            stall_i  <= s0 & s1;
            wait_req <= w0 & w1;
        end else begin
            stall_i  <= 1'b0;
            wait_req <= 1'b0;
        end
    endtask

    // runs one table row, a flush on the old path and then a redirect to its start
    task automatic run_row(input int r);
        int          got;
        int          row_errors;
        logic [36:0] entry;
        pc_t         pc_exp;
        logic        held;
        logic        held_valid;
        instr_t      held_instr;
        pc_t         held_pc;
        pc_t         held_next;
        logic [1:0]  held_kind;
        pc_t         prev_addr;
        got        = 0;
        row_errors = errors;
        pc_exp     = ROW_START[r];
        @(posedge clk_i);
        flush_i  <= 1'b1;   // old path still delivering
        stall_i  <= 1'b0;
        wait_req <= 1'b0;
        @(posedge clk_i);
        flush_i          <= 1'b0;
        redirect_valid_i <= 1'b1;
        redirect_pc_i    <= ROW_START[r];
        @(negedge clk_i);
        check("instr_valid_o", {31'd0, instr_valid_o}, 32'd0);
        check("imem_addr_o", imem_addr, {ROW_START[r][31:2], 2'b00});
        @(posedge clk_i);
        redirect_valid_i <= 1'b0;
        @(negedge clk_i);
        held      = 1'b0;
        prev_addr = imem_addr;
        while (got < ROW_COUNT[r]) begin
            if (held) begin   // stalled cycle must not change the output
                check("instr_valid_o", {31'd0, instr_valid_o}, {31'd0, held_valid});
                check("instr_o", instr_o, held_instr);
                check("instr_pc_o", instr_pc_o, held_pc);
                check("instr_pc_next_o", instr_pc_next_o, held_next);
                check("instr_kind_o", {30'd0, instr_kind_o}, {30'd0, held_kind});
            end
            if (stall_i) begin   // address frozen with the pipeline
                check("imem_addr_o", imem_addr, prev_addr);
            end
            if (instr_valid_o && !stall_i) begin
                entry = ENTRY_TAB[ROW_FIRST[r] + got];
                check("instr_pc_o", instr_pc_o, pc_exp);
                check("instr_o", instr_o, entry[36:5]);
                check("instr_kind_o", {30'd0, instr_kind_o}, {30'd0, entry[4:3]});
                pc_exp = pc_exp + {29'd0, entry[2:0]};
                check("instr_pc_next_o", instr_pc_next_o, pc_exp);
                got++;
            end
            held       = stall_i;
            held_valid = instr_valid_o;
            held_instr = instr_o;
            held_pc    = instr_pc_o;
            held_next  = instr_pc_next_o;
            held_kind  = instr_kind_o;
            prev_addr  = imem_addr;
            @(posedge clk_i);
            drive_random(ROW_RANDOM[r]);
            @(negedge clk_i);
        end
        $display("%s: %0d instructions, %0d errors", row_name[r], got, errors - row_errors);
    endtask

    initial begin
        clk_i            = 1'b0;
        rst_i            = 1'b1;
        stall_i          = 1'b0;
        flush_i          = 1'b0;
        redirect_valid_i = 1'b0;
        redirect_pc_i    = 32'h0;
        wait_req         = 1'b0;
        lfsr             = 16'd68;
        checks           = 0;
        errors           = 0;
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check("instr_valid_o", {31'd0, instr_valid_o}, 32'd0);
        check("imem_addr_o", imem_addr, 32'h4000_0000);   // word of the reset pc
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("rows %0d, checks %0d, errors %0d", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // watchdog, 40 cycles per expected instruction
    initial begin
        int limit;
        limit = 8;   // reset margin
        for (int r = 0; r < NUM_ROWS; r++) begin
            limit = limit + 40 * ROW_COUNT[r];
        end
        repeat (limit) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

/* testbench/imem_model.sv */
`timescale 1ns/1ps

module imem_model #(
    parameter logic [31:0] BASE = 32'h4000_0000
) (
    input  logic        clk_i,
    input  logic [31:0] addr_i,
    input  logic        wait_req_i,
    output logic [31:0] data_o,
    output logic        wait_o
);
    // program at BASE: aligned 32-bit words, then every compressed form
    localparam logic [15:0] PROG_LOW [36] = '{
        16'h0093, 16'h0050, 16'h8463, 16'h0020, 16'h00ef, 16'h0100, 16'h8067, 16'h0000,
        16'h0800, 16'h4044, 16'hc404, 16'h0001, 16'h147d, 16'h2021, 16'h4515, 16'h6105,
        16'h6585, 16'h8009, 16'h8409, 16'h881d, 16'h8c05, 16'h8c25, 16'h8c45, 16'h8c65,
        16'hbff5, 16'hc019, 16'he019, 16'h040e, 16'h4522, 16'h8082, 16'h852e, 16'h9002,
        16'h9082, 16'h952e, 16'hc226, 16'h2000
    };

    // mixed stream at BASE + 0x100, with split 32-bit instructions
    localparam logic [15:0] PROG_HIGH [16] = '{
        16'h4515, 16'h0093, 16'h0050, 16'h0001, 16'h8463, 16'h0020, 16'hc019, 16'h00ef,
        16'h0100, 16'h8082, 16'h8067, 16'h0000, 16'h852e, 16'h2223, 16'h0091, 16'h9002
    };

    logic [15:0] mem [512];   // 1 KiB window of halfwords
    logic [31:0] offset;
    logic [31:0] fill;

    assign offset = addr_i - BASE;
    assign wait_o = wait_req_i;

    initial begin
        data_o = 32'h0;
        for (int i = 0; i < 512; i++) begin
            fill   = (i * 32'h9e37) ^ 32'h3c5a;   // scrambled by address
            mem[i] = fill[15:0];
        end
        for (int i = 0; i < 36; i++) begin
            mem[i] = PROG_LOW[i];
        end
        for (int i = 0; i < 16; i++) begin
            mem[128 + i] = PROG_HIGH[i];
        end
    end

    always @(posedge clk_i) begin
        data_o <= {mem[{offset[9:2], 1'b1}], mem[{offset[9:2], 1'b0}]};   // one cycle read
    end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
    parameter fetch_pkg::pc_t RESET_PC = 32'h4000_0000
) (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   redirect_valid_i,
    input  fetch_pkg::pc_t         redirect_pc_i,
    input  fetch_pkg::instr_t      imem_data_i,
    input  logic                   imem_wait_i,
    output fetch_pkg::pc_t         imem_addr_o,
    output logic                   instr_valid_o,
    output fetch_pkg::instr_t      instr_o,
    output fetch_pkg::pc_t         instr_pc_o,
    output fetch_pkg::pc_t         instr_pc_next_o,
    output fetch_pkg::instr_kind_e instr_kind_o
);
    import fetch_pkg::*;

    pc_t        data_pc;       // pc of the word arriving now
    logic       data_live;
    logic [2:0] consume_len;   // 0, 2 or 4 bytes
    logic       asm_valid;
    instr_t     asm_instr;
    pc_t        asm_pc;
    logic [2:0] asm_len;

    // first stage, address generation
    pc_gen #(
        .RESET_PC (RESET_PC)
    ) i_pc_gen (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .imem_wait_i      (imem_wait_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .consume_len_i    (consume_len),
        .imem_addr_o      (imem_addr_o),
        .data_pc_o        (data_pc),
        .data_live_o      (data_live)
    );

    // parcel extraction and rvc expansion
    fetch_align i_fetch_align (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .imem_wait_i      (imem_wait_i),
        .redirect_valid_i (redirect_valid_i),
        .data_live_i      (data_live),
        .data_pc_i        (data_pc),
        .imem_data_i      (imem_data_i),
        .consume_len_o    (consume_len),
        .asm_valid_o      (asm_valid),
        .asm_instr_o      (asm_instr),
        .asm_pc_o         (asm_pc),
        .asm_len_o        (asm_len)
    );

    fetch_out_reg i_fetch_out_reg (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .imem_wait_i      (imem_wait_i),
        .flush_i          (flush_i),
        .redirect_valid_i (redirect_valid_i),
        .asm_valid_i      (asm_valid),
        .asm_instr_i      (asm_instr),
        .asm_pc_i         (asm_pc),
        .asm_len_i        (asm_len),
        .instr_valid_o    (instr_valid_o),
        .instr_o          (instr_o),
        .instr_pc_o       (instr_pc_o),
        .instr_pc_next_o  (instr_pc_next_o),
        .instr_kind_o     (instr_kind_o)
    );

endmodule

/* src/fetch_out_reg.sv */
`timescale 1ns/1ps

module fetch_out_reg (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   stall_i,
    input  logic                   imem_wait_i,
    input  logic                   flush_i,
    input  logic                   redirect_valid_i,
    input  logic                   asm_valid_i,
    input  fetch_pkg::instr_t      asm_instr_i,
    input  fetch_pkg::pc_t         asm_pc_i,
    input  logic [2:0]             asm_len_i,
    output logic                   instr_valid_o,
    output fetch_pkg::instr_t      instr_o,
    output fetch_pkg::pc_t         instr_pc_o,
    output fetch_pkg::pc_t         instr_pc_next_o,
    output fetch_pkg::instr_kind_e instr_kind_o
);
    import fetch_pkg::*;

    logic        bubble;
    instr_kind_e kind_d;

    assign bubble = flush_i | redirect_valid_i | imem_wait_i | ~asm_valid_i;

    // classify on the expanded opcode
    always_comb begin
        case (asm_instr_i[6:0])
            OPC_BRANCH: kind_d = KIND_BRANCH;
            OPC_JAL,
            OPC_JALR:   kind_d = KIND_JUMP;
            default:    kind_d = KIND_OTHER;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            instr_valid_o <= 1'b0;
            instr_o       <= BUBBLE_INSTR;
            instr_kind_o  <= KIND_OTHER;
        end else if (!stall_i) begin
            instr_valid_o <= ~bubble;
            instr_o       <= bubble ? BUBBLE_INSTR : asm_instr_i;
            instr_kind_o  <= bubble ? KIND_OTHER : kind_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            instr_pc_o      <= asm_pc_i;
            instr_pc_next_o <= asm_pc_i + {29'd0, asm_len_i};   // fall-through
        end
    end

    a_flush_bubble: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (flush_i && !stall_i) |=> !instr_valid_o
    );

endmodule

/* src/fetch_align.sv */
`timescale 1ns/1ps

module fetch_align (
    input  logic              clk_i,
    input  logic              rst_i,
    input  logic              stall_i,
    input  logic              imem_wait_i,
    input  logic              redirect_valid_i,
    input  logic              data_live_i,
    input  fetch_pkg::pc_t    data_pc_i,
    input  fetch_pkg::instr_t imem_data_i,
    output logic [2:0]        consume_len_o,
    output logic              asm_valid_o,
    output fetch_pkg::instr_t asm_instr_o,
    output fetch_pkg::pc_t    asm_pc_o,
    output logic [2:0]        asm_len_o
);
    import fetch_pkg::*;

    align_state_e state_q;
    align_state_e state_d;
    half_t        hold_q;      // lower parcel of a split instruction
    pc_t          hold_pc_q;   // its pc
    half_t        parcel;
    instr_t       parcel_exp;
    logic         parcel_c;
    logic         data_ok;
    logic         load_hold;

    // arriving word is usable this cycle
    assign data_ok  = data_live_i & ~imem_wait_i & ~redirect_valid_i;

    assign parcel   = data_pc_i[1] ? imem_data_i[31:16] : imem_data_i[15:0];
    assign parcel_c = (parcel[1:0] != 2'b11);

    rvc_expand i_rvc_expand (
        .parcel_i (parcel),
        .instr_o  (parcel_exp)
    );

    always_comb begin
        state_d       = state_q;
        load_hold     = 1'b0;
        consume_len_o = 3'd0;
        asm_valid_o   = 1'b0;
        asm_instr_o   = imem_data_i;
        asm_pc_o      = data_pc_i;
        asm_len_o     = 3'd4;
        if (state_q == ALIGN_SECOND_HALF) begin
            // upper half sits in the low parcel of this word
            asm_instr_o = {imem_data_i[15:0], hold_q};
            asm_pc_o    = hold_pc_q;
            if (data_ok) begin
                asm_valid_o   = 1'b1;
                consume_len_o = 3'd2;
                state_d       = ALIGN_IDLE;
            end
        end else if (parcel_c) begin
            asm_instr_o = parcel_exp;
            asm_len_o   = 3'd2;
            if (data_ok) begin
                asm_valid_o   = 1'b1;
                consume_len_o = 3'd2;
            end
        end else if (!data_pc_i[1]) begin
            if (data_ok) begin   // whole 32-bit word
                asm_valid_o   = 1'b1;
                consume_len_o = 3'd4;
            end
        end else if (data_ok) begin
            // 32-bit start in the upper half, fetch the next word
            load_hold     = 1'b1;
            consume_len_o = 3'd2;
            state_d       = ALIGN_SECOND_HALF;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ALIGN_IDLE;
        end else if (!stall_i) begin
            state_q <= redirect_valid_i ? ALIGN_IDLE : state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!stall_i && load_hold) begin
            hold_q    <= parcel;
            hold_pc_q <= data_pc_i;
        end
    end

    a_split_entry: assert property (
        @(posedge clk_i) disable iff (rst_i)
        (state_q == ALIGN_IDLE) |=> (state_q == ALIGN_IDLE)
            || $past(data_pc_i[1] && (parcel[1:0] == 2'b11))
    );

endmodule

/* src/pc_gen.sv */
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::pc_t RESET_PC = 32'h4000_0000
) (
    input  logic           clk_i,
    input  logic           rst_i,
    input  logic           stall_i,
    input  logic           imem_wait_i,
    input  logic           redirect_valid_i,
    input  fetch_pkg::pc_t redirect_pc_i,
    input  logic [2:0]     consume_len_i,
    output fetch_pkg::pc_t imem_addr_o,
    output fetch_pkg::pc_t data_pc_o,
    output logic           data_live_o
);
    import fetch_pkg::*;

    pc_t  data_pc_q;   // pc of the word coming back from memory
    logic live_q;
    pc_t  pc_seq;
    pc_t  pc_next;

    assign pc_seq = data_pc_q + {29'd0, consume_len_i};

    // pc whose word is requested this cycle
    always_comb begin
        if (stall_i) begin
            pc_next = data_pc_q;   // same word again, data must still match data_pc
        end else if (redirect_valid_i) begin
            pc_next = redirect_pc_i;
        end else if (imem_wait_i) begin
            pc_next = data_pc_q;
        end else begin
            pc_next = pc_seq;
        end
    end

    assign imem_addr_o = {pc_next[31:2], 2'b00};   // word address
    assign data_pc_o   = data_pc_q;
    assign data_live_o = live_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            data_pc_q <= RESET_PC;
            live_q    <= 1'b0;   // first word not requested yet
        end else if (!stall_i) begin
            data_pc_q <= pc_next;
            if (redirect_valid_i) begin
                // target word is taken once the path has settled
                live_q <= 1'b0;
            end else begin
                live_q <= 1'b1;
            end
        end
    end

    // halfword granularity holds for reset, redirect and sequential paths
    a_pc_halfword: assert property (
        @(posedge clk_i) disable iff (rst_i)
        !data_pc_q[0]
    );

endmodule

/* src/rvc_expand.sv */
`timescale 1ns/1ps

module rvc_expand (
    input  fetch_pkg::half_t  parcel_i,
    output fetch_pkg::instr_t instr_o
);
    import fetch_pkg::*;

    localparam logic [6:0] OPC_LOAD   = 7'h03;
    localparam logic [6:0] OPC_OP_IMM = 7'h13;
    localparam logic [6:0] OPC_STORE  = 7'h23;
    localparam logic [6:0] OPC_OP     = 7'h33;
    localparam logic [6:0] OPC_LUI    = 7'h37;

    logic [2:0]  funct3;
    logic [4:0]  rd;        // full 5-bit rd/rs1 field
    logic [4:0]  rs2;
    logic [4:0]  rs1_c;     // x8..x15 from bits 9:7
    logic [4:0]  rs2_c;     // x8..x15 from bits 4:2
    logic [11:0] imm6_sx;   // sign-extended 6-bit immediate
    logic [19:0] jal_imm;   // c.j/c.jal offset in jal field order

    assign funct3  = parcel_i[15:13];
    assign rd      = parcel_i[11:7];
    assign rs2     = parcel_i[6:2];
    assign rs1_c   = {2'b01, parcel_i[9:7]};
    assign rs2_c   = {2'b01, parcel_i[4:2]};
    assign imm6_sx = {{6{parcel_i[12]}}, parcel_i[12], parcel_i[6:2]};
    assign jal_imm = {parcel_i[12], parcel_i[8], parcel_i[10:9], parcel_i[6], parcel_i[7],
                      parcel_i[2], parcel_i[11], parcel_i[5:3], {9{parcel_i[12]}}};

    always_comb begin
        instr_o = ILLEGAL_INSTR;   // fp and reserved forms stay illegal
        case (parcel_i[1:0])
            2'b00: begin
                case (funct3)
                    3'b000: begin   // c.addi4spn, zero immediate is reserved
                        if (parcel_i[12:5] != 8'd0) begin
                            instr_o = {2'b00, parcel_i[10:7], parcel_i[12:11], parcel_i[5],
                                       parcel_i[6], 2'b00, 5'd2, 3'b000, rs2_c, OPC_OP_IMM};
                        end
                    end
                    3'b010: instr_o = {5'd0, parcel_i[5], parcel_i[12:10], parcel_i[6], 2'b00,
                                       rs1_c, 3'b010, rs2_c, OPC_LOAD};   // c.lw
                    3'b110: instr_o = {5'd0, parcel_i[5], parcel_i[12], rs2_c, rs1_c, 3'b010,
                                       parcel_i[11:10], parcel_i[6], 2'b00, OPC_STORE}; // c.sw
                    default: instr_o = ILLEGAL_INSTR;
                endcase
            end
            2'b01: begin
                case (funct3)
                    3'b000: instr_o = {imm6_sx, rd, 3'b000, rd, OPC_OP_IMM};   // c.nop/c.addi
                    3'b001: instr_o = {jal_imm, 5'd1, OPC_JAL};                // c.jal
                    3'b010: instr_o = {imm6_sx, 5'd0, 3'b000, rd, OPC_OP_IMM}; // c.li
                    3'b011: begin
                        if ({parcel_i[12], parcel_i[6:2]} == 6'd0) begin
                            instr_o = ILLEGAL_INSTR;
                        end else if (rd == 5'd2) begin   // c.addi16sp
                            instr_o = {{3{parcel_i[12]}}, parcel_i[4:3], parcel_i[5], parcel_i[2],
                                       parcel_i[6], 4'b0000, 5'd2, 3'b000, 5'd2, OPC_OP_IMM};
                        end else begin   // c.lui
                            instr_o = {{8{parcel_i[12]}}, imm6_sx, rd, OPC_LUI};
                        end
                    end
                    3'b100: begin
                        case (parcel_i[11:10])
                            2'b00: begin   // c.srli
                                if (!parcel_i[12]) begin
                                    instr_o = {7'b0000000, rs2, rs1_c, 3'b101, rs1_c, OPC_OP_IMM};
                                end
                            end
                            2'b01: begin   // c.srai
                                if (!parcel_i[12]) begin
                                    instr_o = {7'b0100000, rs2, rs1_c, 3'b101, rs1_c, OPC_OP_IMM};
                                end
                            end
                            2'b10: instr_o = {imm6_sx, rs1_c, 3'b111, rs1_c, OPC_OP_IMM}; // c.andi
                            default: begin
                                if (!parcel_i[12]) begin   // bit 12 set is rv64 only
                                    case (parcel_i[6:5])
                                        2'b00: instr_o = {7'b0100000, rs2_c, rs1_c, 3'b000,
                                                          rs1_c, OPC_OP};   // c.sub
                                        2'b01: instr_o = {7'b0000000, rs2_c, rs1_c, 3'b100,
                                                          rs1_c, OPC_OP};   // c.xor
                                        2'b10: instr_o = {7'b0000000, rs2_c, rs1_c, 3'b110,
                                                          rs1_c, OPC_OP};   // c.or
                                        default: instr_o = {7'b0000000, rs2_c, rs1_c, 3'b111,
                                                            rs1_c, OPC_OP}; // c.and
                                    endcase
                                end
                            end
                        endcase
                    end
                    3'b101: instr_o = {jal_imm, 5'd0, OPC_JAL};   // c.j
                    default: begin   // c.beqz / c.bnez, funct3 lsb picks bne
                        instr_o = {{4{parcel_i[12]}}, parcel_i[6:5], parcel_i[2], 5'd0, rs1_c,
                                   2'b00, parcel_i[13], parcel_i[11:10], parcel_i[4:3],
                                   parcel_i[12], OPC_BRANCH};
                    end
                endcase
            end
            2'b10: begin
                case (funct3)
                    3'b000: begin   // c.slli
                        if (!parcel_i[12]) begin
                            instr_o = {7'b0000000, rs2, rd, 3'b001, rd, OPC_OP_IMM};
                        end
                    end
                    3'b010: begin   // c.lwsp, rd zero reserved
                        if (rd != 5'd0) begin
                            instr_o = {4'b0000, parcel_i[3:2], parcel_i[12], parcel_i[6:4], 2'b00,
                                       5'd2, 3'b010, rd, OPC_LOAD};
                        end
                    end
                    3'b100: begin
                        if (!parcel_i[12]) begin
                            if (rs2 != 5'd0) begin
                                instr_o = {7'b0000000, rs2, 5'd0, 3'b000, rd, OPC_OP};  // c.mv
                            end else if (rd != 5'd0) begin
                                instr_o = {12'd0, rd, 3'b000, 5'd0, OPC_JALR};         // c.jr
                            end
                        end else if (rs2 != 5'd0) begin
                            instr_o = {7'b0000000, rs2, rd, 3'b000, rd, OPC_OP};        // c.add
                        end else if (rd != 5'd0) begin
                            instr_o = {12'd0, rd, 3'b000, 5'd1, OPC_JALR};             // c.jalr
                        end else begin
                            instr_o = BUBBLE_INSTR;   // c.ebreak, same word as the bubble
                        end
                    end
                    3'b110: instr_o = {4'b0000, parcel_i[8:7], parcel_i[12], rs2, 5'd2, 3'b010,
                                       parcel_i[11:9], 2'b00, OPC_STORE};   // c.swsp
                    default: instr_o = ILLEGAL_INSTR;
                endcase
            end
            default: instr_o = ILLEGAL_INSTR;   // not a compressed parcel
        endcase
    end

endmodule

/* src/fetch_pkg.sv */
package fetch_pkg;

    // byte address, bit 0 always zero
    typedef logic [31:0] pc_t;

    // full instruction, also the memory word
    typedef logic [31:0] instr_t;

    // one 16-bit parcel of the instruction stream
    typedef logic [15:0] half_t;

    // alignment buffer state
    typedef enum logic {
        ALIGN_IDLE,         // nothing buffered
        ALIGN_SECOND_HALF   // lower parcel of a split instruction is held
    } align_state_e;

    // coarse control-flow class handed to decode
    typedef enum logic [1:0] {
        KIND_OTHER  = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_JUMP   = 2'd2
    } instr_kind_e;

    // major opcodes needed by fetch
    localparam logic [6:0] OPC_BRANCH = 7'h63;
    localparam logic [6:0] OPC_JAL    = 7'h6f;
    localparam logic [6:0] OPC_JALR   = 7'h67;

    // ebreak, shown on the output whenever no instruction is valid
    localparam instr_t BUBBLE_INSTR = 32'h0010_0073;

    // canonical illegal instruction
    localparam instr_t ILLEGAL_INSTR = 32'h0000_0000;

endpackage
